//--- src/sa_ctrl_pkg.sv
package sa_ctrl_pkg;

    // Element and address widths
    localparam int DATA_W = 8;
    localparam int ADDR_W = 6;

    // Matrix geometry
    localparam int W_DIM   = 3;           // Weight matrix side
    localparam int F_DIM   = 4;           // Feature matrix side
    localparam int WIN_DIM = 2;           // Windows per side

    // Scratch memory layout
    localparam int WEIGHT_BASE  = 0;
    localparam int FEATURE_BASE = WEIGHT_BASE + W_DIM * W_DIM;
    localparam int INIT_WORDS   = W_DIM * W_DIM + F_DIM * F_DIM;

    localparam int N_STRIDES = WIN_DIM * WIN_DIM;

    // Pipeline flush after each compute pass
    localparam int SERIAL_DRAIN   = 2;
    localparam int SYSTOLIC_DRAIN = 3;
    localparam int DRAIN_W        = $clog2(SYSTOLIC_DRAIN);

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [$clog2(N_STRIDES)-1:0] stride_idx_t;

    // Weights stored column by column
    localparam data_t WEIGHT_INIT [W_DIM*W_DIM] = '{
        8'd1, 8'd1, 8'd1,
        8'd2, 8'd2, 8'd2,
        8'd3, 8'd3, 8'd3
    };

    // Features stored row by row
    localparam data_t FEATURE_INIT [F_DIM*F_DIM] = '{
        8'd1, 8'd2, 8'd3, 8'd4,
        8'd1, 8'd2, 8'd3, 8'd4,
        8'd1, 8'd2, 8'd3, 8'd4,
        8'd1, 8'd2, 8'd3, 8'd4
    };

    typedef enum logic [1:0] {
        COMP_SERIAL   = 2'd0,
        COMP_SYSTOLIC = 2'd1
    } comp_mode_t;

    typedef enum logic [3:0] {
        PH_IDLE,
        PH_MEM_INIT,
        PH_SERIAL,
        PH_SERIAL_DRAIN,
        PH_WEIGHT_PRELOAD,
        PH_SYSTOLIC,
        PH_SYSTOLIC_DRAIN,
        PH_DISPLAY_START,
        PH_DISPLAY
    } phase_t;

endpackage

//--- src/mem_init_seq.sv
`timescale 1ns/1ps

module mem_init_seq import sa_ctrl_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  init_start,
    output logic  mem_we,
    output addr_t mem_addr,
    output data_t mem_wdata,
    output logic  init_done
);

    typedef logic [$clog2(W_DIM*W_DIM)-1:0] w_idx_t;
    typedef logic [$clog2(F_DIM*F_DIM)-1:0] f_idx_t;

    logic active;
    addr_t word_cnt;
    logic last_word;
    w_idx_t w_idx;
    f_idx_t f_idx;

    assign last_word = (word_cnt == addr_t'(INIT_WORDS - 1));

    always_ff @(posedge clk) begin
        if (!rst) begin
            active   <= 1'b0;
            word_cnt <= '0;
        end else if (init_start) begin
            active   <= 1'b1;
            word_cnt <= '0;
        end else if (active) begin
            word_cnt <= last_word ? '0 : word_cnt + 1'b1;
            if (last_word)
                active <= 1'b0;
        end
    end

    assign w_idx = w_idx_t'(word_cnt);
    assign f_idx = f_idx_t'(word_cnt - addr_t'(FEATURE_BASE));

    // Weights fill the low addresses, features follow
    always_comb begin
        if (word_cnt < addr_t'(FEATURE_BASE))
            mem_wdata = WEIGHT_INIT[w_idx];
        else
            mem_wdata = FEATURE_INIT[f_idx];
    end

    assign mem_addr  = addr_t'(WEIGHT_BASE) + word_cnt;
    assign mem_we    = active;
    assign init_done = active && last_word;   // Same cycle as the last write

    // A write burst covers the scratch area once
    a_we_burst: assert property (@(posedge clk) disable iff (!rst)
        mem_we [*INIT_WORDS] |=> !mem_we);

endmodule

//--- src/stride_seq.sv
`timescale 1ns/1ps

module stride_seq import sa_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        stride_start,
    input  logic        stride_unit_done,
    output logic        stride_active,
    output stride_idx_t stride_idx,
    output addr_t       feature_baseaddr,
    output logic        stride_done
);

    logic active;
    stride_idx_t idx;
    logic last_win;
    addr_t win_row;
    addr_t win_col;

    assign last_win = (idx == stride_idx_t'(N_STRIDES - 1));

    // Window index walks row-major over the output grid
    always_ff @(posedge clk) begin
        if (!rst) begin
            active <= 1'b0;
            idx    <= '0;
        end else if (stride_start) begin
            active <= 1'b1;
            idx    <= '0;
        end else if (active && stride_unit_done) begin
            idx <= last_win ? '0 : idx + 1'b1;
            if (last_win)
                active <= 1'b0;
        end
    end

    assign win_row = addr_t'(int'(idx) / WIN_DIM);
    assign win_col = addr_t'(int'(idx) % WIN_DIM);

    // Top-left feature of the window
    assign feature_baseaddr = addr_t'(FEATURE_BASE) + win_row * addr_t'(F_DIM) + win_col;

    assign stride_active = active;
    assign stride_idx    = idx;
    assign stride_done   = active && stride_unit_done && last_win;

    // Window only moves on a unit answer
    a_idx_hold: assert property (@(posedge clk) disable iff (!rst)
        !$stable(stride_idx) |-> $past(stride_unit_done));

    // Phase FSM must not restart a pass in flight
    a_no_restart: assert property (@(posedge clk) disable iff (!rst)
        stride_start |-> !stride_active);

endmodule

//--- src/phase_fsm.sv
`timescale 1ns/1ps

module phase_fsm import sa_ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       start_sa,
    input  logic       serial_mode_done,
    input  logic       weight_preloader_done,
    input  logic       feature_loader_done,
    input  logic       display_done,
    input  logic       init_done,
    input  logic       stride_active,
    input  logic       stride_done,
    output logic       init_start,
    output logic       stride_start,
    output logic       stride_unit_done,
    output logic       rst_computation_module,
    output logic       rst_display_module,
    output logic       mem_sel,
    output logic       serial_mode_en,
    output logic       weight_preloader_en,
    output logic       feature_loader_en,
    output logic       systolic_mode,
    output logic       display_mode_en,
    output logic       busy,
    output comp_mode_t computation_mode_sel
);

    phase_t phase;
    phase_t phase_nxt;
    logic [DRAIN_W-1:0] drain_cnt;
    logic in_drain;
    logic drain_last;
    logic comp_phase;

    assign in_drain = (phase == PH_SERIAL_DRAIN) || (phase == PH_SYSTOLIC_DRAIN);

    assign drain_last =
        ((phase == PH_SERIAL_DRAIN) && (drain_cnt == DRAIN_W'(SERIAL_DRAIN - 1))) ||
        ((phase == PH_SYSTOLIC_DRAIN) && (drain_cnt == DRAIN_W'(SYSTOLIC_DRAIN - 1)));

    always_comb begin
        phase_nxt = phase;
        case (phase)
            PH_IDLE:           if (start_sa) phase_nxt = PH_MEM_INIT;
            PH_MEM_INIT:       if (init_done) phase_nxt = PH_SERIAL;
            PH_SERIAL:         if (stride_done) phase_nxt = PH_SERIAL_DRAIN;
            PH_SERIAL_DRAIN:   if (drain_last) phase_nxt = PH_WEIGHT_PRELOAD;
            PH_WEIGHT_PRELOAD: if (weight_preloader_done) phase_nxt = PH_SYSTOLIC;
            PH_SYSTOLIC:       if (stride_done) phase_nxt = PH_SYSTOLIC_DRAIN;
            PH_SYSTOLIC_DRAIN: if (drain_last) phase_nxt = PH_DISPLAY_START;
            PH_DISPLAY_START:  phase_nxt = PH_DISPLAY;
            PH_DISPLAY:        if (display_done) phase_nxt = PH_IDLE;
            default:           phase_nxt = PH_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            phase     <= PH_IDLE;
            drain_cnt <= '0;
        end else begin
            phase <= phase_nxt;
            // Restarts on every phase entry
            if (in_drain && (phase_nxt == phase))
                drain_cnt <= drain_cnt + 1'b1;
            else
                drain_cnt <= '0;
        end
    end

    // Sequencer kick-offs
    assign init_start   = (phase == PH_IDLE) && start_sa;
    assign stride_start = ((phase == PH_MEM_INIT) && init_done) ||
                          ((phase == PH_WEIGHT_PRELOAD) && weight_preloader_done);

    assign serial_mode_en      = (phase == PH_SERIAL) && stride_active;
    assign feature_loader_en   = (phase == PH_SYSTOLIC) && stride_active;
    assign weight_preloader_en = (phase == PH_WEIGHT_PRELOAD);
    assign display_mode_en     = (phase == PH_DISPLAY_START);   // Single-cycle start

    // Only the unit that is enabled may advance the window
    assign stride_unit_done = (serial_mode_en && serial_mode_done) ||
                              (feature_loader_en && feature_loader_done);

    assign comp_phase = phase inside {PH_SERIAL, PH_SERIAL_DRAIN, PH_WEIGHT_PRELOAD,
                                      PH_SYSTOLIC, PH_SYSTOLIC_DRAIN};

    // Compute units come out of reset with the last init write
    assign rst_computation_module = !(comp_phase || ((phase == PH_MEM_INIT) && init_done));
    assign rst_display_module     = !(phase inside {PH_DISPLAY_START, PH_DISPLAY});

    assign mem_sel       = !(phase inside {PH_IDLE, PH_MEM_INIT});
    assign systolic_mode = phase inside {PH_SYSTOLIC, PH_SYSTOLIC_DRAIN};
    assign busy          = (phase != PH_IDLE);

    assign computation_mode_sel =
        (phase inside {PH_WEIGHT_PRELOAD, PH_SYSTOLIC, PH_SYSTOLIC_DRAIN}) ?
        COMP_SYSTOLIC : COMP_SERIAL;

    a_one_unit: assert property (@(posedge clk) disable iff (!rst)
        $onehot0({serial_mode_en, weight_preloader_en, feature_loader_en, display_mode_en}));

endmodule

//--- src/sa_controller.sv
`timescale 1ns/1ps

module sa_controller import sa_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start_sa,
    input  logic        serial_mode_done,
    input  logic        weight_preloader_done,
    input  logic        feature_loader_done,
    input  logic        display_done,
    output logic        mem_we,
    output addr_t       mem_addr,
    output data_t       mem_wdata,
    output logic        rst_computation_module,
    output logic        rst_display_module,
    output logic        mem_sel,
    output addr_t       feature_baseaddr,    // Shared by serial and systolic modes
    output logic        serial_mode_en,
    output logic        weight_preloader_en,
    output logic        feature_loader_en,
    output logic        systolic_mode,
    output stride_idx_t c_reg_sel,
    output comp_mode_t  computation_mode_sel,
    output logic        display_mode_en,
    output logic        busy
);

    logic init_start;
    logic init_done;
    logic stride_start;
    logic stride_done;
    logic stride_active;
    logic stride_unit_done;

    mem_init_seq mem_init_seq_inst (
        .clk        (clk),
        .rst        (rst),
        .init_start (init_start),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .init_done  (init_done)
    );

    // Window index doubles as the result register select
    stride_seq stride_seq_inst (
        .clk              (clk),
        .rst              (rst),
        .stride_start     (stride_start),
        .stride_unit_done (stride_unit_done),
        .stride_active    (stride_active),
        .stride_idx       (c_reg_sel),
        .feature_baseaddr (feature_baseaddr),
        .stride_done      (stride_done)
    );

    phase_fsm phase_fsm_inst (
        .clk                    (clk),
        .rst                    (rst),
        .start_sa               (start_sa),
        .serial_mode_done       (serial_mode_done),
        .weight_preloader_done  (weight_preloader_done),
        .feature_loader_done    (feature_loader_done),
        .display_done           (display_done),
        .init_done              (init_done),
        .stride_active          (stride_active),
        .stride_done            (stride_done),
        .init_start             (init_start),
        .stride_start           (stride_start),
        .stride_unit_done       (stride_unit_done),
        .rst_computation_module (rst_computation_module),
        .rst_display_module     (rst_display_module),
        .mem_sel                (mem_sel),
        .serial_mode_en         (serial_mode_en),
        .weight_preloader_en    (weight_preloader_en),
        .feature_loader_en      (feature_loader_en),
        .systolic_mode          (systolic_mode),
        .display_mode_en        (display_mode_en),
        .busy                   (busy),
        .computation_mode_sel   (computation_mode_sel)
    );

endmodule

//--- tests/ctrl_checker.sv
`timescale 1ns/1ps

module ctrl_checker import sa_ctrl_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        start_sa,
    input  logic        serial_mode_done,
    input  logic        weight_preloader_done,
    input  logic        feature_loader_done,
    input  logic        display_done,
    input  logic        mem_we,
    input  addr_t       mem_addr,
    input  data_t       mem_wdata,
    input  logic        rst_computation_module,
    input  logic        rst_display_module,
    input  logic        mem_sel,
    input  addr_t       feature_baseaddr,
    input  logic        serial_mode_en,
    input  logic        weight_preloader_en,
    input  logic        feature_loader_en,
    input  logic        systolic_mode,
    input  stride_idx_t c_reg_sel,
    input  comp_mode_t  computation_mode_sel,
    input  logic        display_mode_en,
    input  logic        busy,
    output int          error_count,
    output int          init_count,
    output int          run_count
);

    phase_t p;          // Reference phase
    int word;
    int win;
    int drain;
    logic prev_we;
    logic prev_busy;

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        if (exp !== got) begin
            $display("error: %s expected %h got %h at %0t", name, exp, got, $time);
            error_count++;
        end
    endtask

    // Top-left feature of window k, from the geometry
    function automatic int window_base(input int k);
        return FEATURE_BASE + (k / WIN_DIM) * F_DIM + (k % WIN_DIM);
    endfunction

    function automatic int init_data(input int w);
        if (w < FEATURE_BASE)
            return int'(WEIGHT_INIT[w - WEIGHT_BASE]);
        return int'(FEATURE_INIT[w - FEATURE_BASE]);
    endfunction

    task automatic compare_outputs();
        logic comp_ph;
        logic sys_sel;
        comp_ph = p inside {PH_SERIAL, PH_SERIAL_DRAIN, PH_WEIGHT_PRELOAD,
                            PH_SYSTOLIC, PH_SYSTOLIC_DRAIN};
        sys_sel = p inside {PH_WEIGHT_PRELOAD, PH_SYSTOLIC, PH_SYSTOLIC_DRAIN};
        compare_value("mem_we", 32'(p == PH_MEM_INIT), 32'(mem_we));
        if (p == PH_MEM_INIT) begin
            compare_value("mem_addr", 32'(word), 32'(mem_addr));
            compare_value("mem_wdata", 32'(init_data(word)), 32'(mem_wdata));
        end
        compare_value("serial_mode_en", 32'(p == PH_SERIAL), 32'(serial_mode_en));
        compare_value("weight_preloader_en", 32'(p == PH_WEIGHT_PRELOAD),
                      32'(weight_preloader_en));
        compare_value("feature_loader_en", 32'(p == PH_SYSTOLIC), 32'(feature_loader_en));
        compare_value("display_mode_en", 32'(p == PH_DISPLAY_START), 32'(display_mode_en));
        if (p inside {PH_SERIAL, PH_SYSTOLIC})
            compare_value("feature_baseaddr", 32'(window_base(win)), 32'(feature_baseaddr));
        if (p == PH_SYSTOLIC)
            compare_value("c_reg_sel", 32'(win), 32'(c_reg_sel));
        compare_value("computation_mode_sel", sys_sel ? 32'(COMP_SYSTOLIC) : 32'(COMP_SERIAL),
                      32'(computation_mode_sel));
        compare_value("systolic_mode", 32'(p inside {PH_SYSTOLIC, PH_SYSTOLIC_DRAIN}),
                      32'(systolic_mode));
        compare_value("mem_sel", 32'(!(p inside {PH_IDLE, PH_MEM_INIT})), 32'(mem_sel));
        compare_value("busy", 32'(p != PH_IDLE), 32'(busy));
        compare_value("rst_computation_module",
                      32'(!(comp_ph || (p == PH_MEM_INIT && word == INIT_WORDS - 1))),
                      32'(rst_computation_module));
        compare_value("rst_display_module",
                      32'(!(p inside {PH_DISPLAY_START, PH_DISPLAY})), 32'(rst_display_module));
    endtask

    initial begin
        error_count = 0;
        init_count  = 0;
        run_count   = 0;
    end

    always @(posedge clk) begin
        if (!rst) begin
            p         <= PH_IDLE;
            word      <= 0;
            win       <= 0;
            drain     <= 0;
            prev_we   <= 1'b0;
            prev_busy <= 1'b0;
        end else begin
            compare_outputs();
            if (mem_we && !prev_we)
                init_count++;
            if (prev_busy && !busy)
                run_count++;
            prev_we   <= mem_we;
            prev_busy <= busy;
            case (p)
                PH_IDLE: if (start_sa) begin
                    p    <= PH_MEM_INIT;
                    word <= 0;
                end
                PH_MEM_INIT: begin
                    if (word == INIT_WORDS - 1) begin
                        p   <= PH_SERIAL;
                        win <= 0;
                    end else
                        word <= word + 1;
                end
                PH_SERIAL: if (serial_mode_done) begin
                    if (win == N_STRIDES - 1) begin
                        p     <= PH_SERIAL_DRAIN;
                        drain <= 0;
                    end else
                        win <= win + 1;
                end
                PH_SERIAL_DRAIN: begin
                    if (drain == SERIAL_DRAIN - 1)
                        p <= PH_WEIGHT_PRELOAD;
                    drain <= drain + 1;
                end
                PH_WEIGHT_PRELOAD: if (weight_preloader_done) begin
                    p   <= PH_SYSTOLIC;
                    win <= 0;
                end
                PH_SYSTOLIC: if (feature_loader_done) begin
                    if (win == N_STRIDES - 1) begin
                        p     <= PH_SYSTOLIC_DRAIN;
                        drain <= 0;
                    end else
                        win <= win + 1;
                end
                PH_SYSTOLIC_DRAIN: begin
                    if (drain == SYSTOLIC_DRAIN - 1)
                        p <= PH_DISPLAY_START;
                    drain <= drain + 1;
                end
                PH_DISPLAY_START: p <= PH_DISPLAY;
                PH_DISPLAY: if (display_done) p <= PH_IDLE;
                default: p <= PH_IDLE;
            endcase
        end
    end

endmodule

//--- tests/tb_sa_controller.sv
`timescale 1ns/1ps

module tb_sa_controller import sa_ctrl_pkg::*; ();

    localparam int RESET_CYCLES   = 5;
    localparam int N_RUNS         = 3;
    localparam int RUN_MAX        = 130;
    localparam int GAP_MAX        = 20;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 2 * N_RUNS * (RUN_MAX + GAP_MAX);

    logic clk;
    logic rst;
    logic start_sa;
    logic [3:0] unit_done;      // Serial, preload, feature loader, display
    logic [3:0] unit_en;
    int delay_cnt [4];
    int seed;
    int cycle_count;
    int seq_errors;

    logic        mem_we;
    addr_t       mem_addr;
    data_t       mem_wdata;
    logic        rst_computation_module;
    logic        rst_display_module;
    logic        mem_sel;
    addr_t       feature_baseaddr;
    logic        serial_mode_en;
    logic        weight_preloader_en;
    logic        feature_loader_en;
    logic        systolic_mode;
    stride_idx_t c_reg_sel;
    comp_mode_t  computation_mode_sel;
    logic        display_mode_en;
    logic        busy;
    int          error_count;
    int          init_count;
    int          run_count;

    sa_controller sa_controller_inst (
        .clk                    (clk),
        .rst                    (rst),
        .start_sa               (start_sa),
        .serial_mode_done       (unit_done[0]),
        .weight_preloader_done  (unit_done[1]),
        .feature_loader_done    (unit_done[2]),
        .display_done           (unit_done[3]),
        .mem_we                 (mem_we),
        .mem_addr               (mem_addr),
        .mem_wdata              (mem_wdata),
        .rst_computation_module (rst_computation_module),
        .rst_display_module     (rst_display_module),
        .mem_sel                (mem_sel),
        .feature_baseaddr       (feature_baseaddr),
        .serial_mode_en         (serial_mode_en),
        .weight_preloader_en    (weight_preloader_en),
        .feature_loader_en      (feature_loader_en),
        .systolic_mode          (systolic_mode),
        .c_reg_sel              (c_reg_sel),
        .computation_mode_sel   (computation_mode_sel),
        .display_mode_en        (display_mode_en),
        .busy                   (busy)
    );

    ctrl_checker ctrl_checker_inst (
        .clk                    (clk),
        .rst                    (rst),
        .start_sa               (start_sa),
        .serial_mode_done       (unit_done[0]),
        .weight_preloader_done  (unit_done[1]),
        .feature_loader_done    (unit_done[2]),
        .display_done           (unit_done[3]),
        .mem_we                 (mem_we),
        .mem_addr               (mem_addr),
        .mem_wdata              (mem_wdata),
        .rst_computation_module (rst_computation_module),
        .rst_display_module     (rst_display_module),
        .mem_sel                (mem_sel),
        .feature_baseaddr       (feature_baseaddr),
        .serial_mode_en         (serial_mode_en),
        .weight_preloader_en    (weight_preloader_en),
        .feature_loader_en      (feature_loader_en),
        .systolic_mode          (systolic_mode),
        .c_reg_sel              (c_reg_sel),
        .computation_mode_sel   (computation_mode_sel),
        .display_mode_en        (display_mode_en),
        .busy                   (busy),
        .error_count            (error_count),
        .init_count             (init_count),
        .run_count              (run_count)
    );

    assign unit_en = {display_mode_en, feature_loader_en, weight_preloader_en, serial_mode_en};

    function automatic int pick_range(input int lo, input int hi);
        return lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Slow units answer each enable after a random delay
    always @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (!rst) begin
                delay_cnt[i] <= 0;
                unit_done[i] <= 1'b0;
            end else if (unit_done[i]) begin
                unit_done[i] <= 1'b0;
            end else if (delay_cnt[i] == 0) begin
                if (unit_en[i])
                    delay_cnt[i] <= pick_range(1, 8);
            end else if (delay_cnt[i] == 1) begin
                delay_cnt[i] <= 0;
                unit_done[i] <= 1'b1;
            end else begin
                delay_cnt[i] <= delay_cnt[i] - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the controller did not finish within %0d cycles",
                     TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    initial begin
        logic seen_busy;
        logic run_over;
        seed        = 32'hdbc0;
        cycle_count = 0;
        seq_errors  = 0;
        rst         = 1'b0;
        start_sa    = 1'b0;
        unit_done   = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b1;

        for (int run = 0; run < N_RUNS; run++) begin
            repeat (pick_range(2, GAP_MAX)) @(posedge clk);
            start_sa  <= 1'b1;
            seen_busy = 1'b0;
            run_over  = 1'b0;
            while (!run_over) begin
                @(posedge clk);
                // Extra starts only where busy is sure to stay high
                if (mem_we || serial_mode_en || feature_loader_en)
                    start_sa <= (pick_range(0, 15) == 0);
                else
                    start_sa <= 1'b0;
                if (seen_busy && !busy)
                    run_over = 1'b1;
                if (busy)
                    seen_busy = 1'b1;
            end
        end
        repeat (3) @(posedge clk);

        if (init_count != N_RUNS) begin
            $display("Wrong number of init sequences: %0d seen for %0d runs",
                     init_count, N_RUNS);
            seq_errors++;
        end
        if (run_count != N_RUNS) begin
            $display("Wrong number of completed runs: %0d seen, %0d expected",
                     run_count, N_RUNS);
            seq_errors++;
        end

        $display("Checks done: %0d value errors, %0d sequence errors",
                 error_count, seq_errors);
        if (error_count == 0 && seq_errors == 0)
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

//--- sim.f
src/sa_ctrl_pkg.sv
src/mem_init_seq.sv
src/stride_seq.sv
src/phase_fsm.sv
src/sa_controller.sv
tests/ctrl_checker.sv
tests/tb_sa_controller.sv

//--- Makefile
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -f sim.f --top-module tb_sa_controller -Mdir obj_dir
	@out=$$(./obj_dir/Vtb_sa_controller); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module tb_sa_controller

clean:
	rm -rf obj_dir
